// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = snes_mem_tb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: sim.f
+incdir+source
source/snes_mem_pkg.sv
source/mem_req_if.sv
source/snes_bus_sync.sv
source/mem_channel.sv
source/mcu_req_router.sv
source/ext_mem_pins.sv
source/snes_mem_top.sv
verification/snes_mem_chk.sv
verification/snes_mem_tb.sv

// File: source/ext_mem_pins.sv
`timescale 1ns/1ps
`default_nettype none

module ext_mem_pins (
  input  snes_mem_pkg::chan_status_t rom_status,
  input  snes_mem_pkg::chan_status_t ram_status,
  input  snes_mem_pkg::rom_addr_t    rom_hit_addr,
  input  snes_mem_pkg::ram_addr_t    ram_hit_addr,
  input  snes_mem_pkg::mcu_addr_t    snes_addr,
  input  snes_mem_pkg::byte_t        mcu_wdata,
  input  logic [15:0]                rom_rdata,
  output logic [22:0]                rom_addr,
  output logic [15:0]                rom_wdata,
  output logic [1:0]                 rom_wdata_en, // [1] high lane, [0] low lane
  output logic                       rom_we,
  output logic                       rom_bhe,
  output logic                       rom_ble,
  output snes_mem_pkg::ram_addr_t    ram_addr,
  output snes_mem_pkg::byte_t        ram_wdata,
  output logic                       ram_wdata_en,
  output logic                       ram_we,
  output snes_mem_pkg::byte_t        rom_byte
);

  logic rom_a0;
  logic rom_hit;

  assign rom_a0  = rom_hit_addr[0];
  assign rom_hit = rom_status.rd_hit | rom_status.wr_hit;

  // psram: word address, odd bytes sit in the low lane
  assign rom_addr     = rom_hit_addr[23:1];
  assign rom_byte     = rom_a0 ? rom_rdata[7:0] : rom_rdata[15:8];
  assign rom_wdata    = {mcu_wdata, mcu_wdata};
  assign rom_wdata_en = {~rom_a0 & rom_status.wr_hit, rom_a0 & rom_status.wr_hit};
  assign rom_we       = ~rom_status.we_hit;
  assign rom_bhe      = rom_a0 | ~rom_hit;  // active low lane selects
  assign rom_ble      = ~rom_a0 | ~rom_hit;

  // sram shows the console address unless the mcu owns it
  assign ram_addr     = (ram_status.rd_hit | ram_status.wr_hit) ? ram_hit_addr
                                                                : snes_addr[18:0];
  assign ram_wdata    = mcu_wdata;
  assign ram_wdata_en = ram_status.wr_hit;
  assign ram_we       = ~ram_status.we_hit;

endmodule

`default_nettype wire

// File: source/mcu_req_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "snes_mem_macros.svh"

module mcu_req_router (
  input  logic                    CLK2,
  input  logic                    reset,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  snes_mem_pkg::mcu_addr_t mcu_addr,
  output snes_mem_pkg::byte_t     mcu_rdata,
  output logic                    mcu_rdy,
  mem_req_if.router               rom_req,
  mem_req_if.router               ram_req
);

  logic is_ram;
  logic rd_last; // last pulse was a read

  // 880000-8fffff is sram, everything else psram
  assign is_ram = (mcu_addr[23:19] == `SNES_RAM_REGION);

  // -------------------------------------------------------------------------
  // request routing
  // -------------------------------------------------------------------------

  assign rom_req.rd_req = mcu_rrq & ~is_ram;
  assign rom_req.wr_req = mcu_wrq & ~is_ram;
  assign rom_req.addr   = mcu_addr;

  assign ram_req.rd_req = mcu_rrq & is_ram;
  assign ram_req.wr_req = mcu_wrq & is_ram;
  assign ram_req.addr   = mcu_addr;

  // either channel busy holds off the mcu
  assign mcu_rdy = rom_req.rdy & ram_req.rdy;

  // -------------------------------------------------------------------------
  // read data return
  // -------------------------------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_last <= 1'b0;
    end else if (mcu_rrq || mcu_wrq) begin
      rd_last <= mcu_rrq;
    end
  end

  // only one access in flight, so at most one done at a time
  always_ff @(posedge CLK2) begin
    if (rd_last) begin
      if (rom_req.done) begin
        mcu_rdata <= rom_req.rdata;
      end else if (ram_req.done) begin
        mcu_rdata <= ram_req.rdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mem_channel.sv
`timescale 1ns/1ps
`default_nettype none
`include "snes_mem_macros.svh"

module mem_channel #(
  parameter type addr_t    = snes_mem_pkg::rom_addr_t,
  parameter int  cycle_len = `SNES_ROM_CYCLE_LEN
) (
  input  logic                       CLK2,
  input  logic                       reset,
  input  logic                       free_slot,
  input  logic                       dead,
  input  logic                       revive,
  mem_req_if.channel                 req,
  input  snes_mem_pkg::byte_t        rd_byte,
  output snes_mem_pkg::chan_status_t status,
  output addr_t                      hit_addr
);

  snes_mem_pkg::chan_state_e state;
  logic [`SNES_DELAY_W-1:0]  delay;
  logic                      rd_pend;
  logic                      wr_pend;
  logic                      at_end;
  addr_t                     addr_r;
  snes_mem_pkg::byte_t       rdata_r;

  assign at_end = (state == snes_mem_pkg::ST_RD_END) ||
                  (state == snes_mem_pkg::ST_WR_END);

  // -------------------------------------------------------------------------
  // request latch
  // -------------------------------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      req.rdy <= 1'b1;
    end else if (req.rd_req) begin
      rd_pend <= 1'b1;
      req.rdy <= 1'b0;
    end else if (req.wr_req) begin
      wr_pend <= 1'b1;
      req.rdy <= 1'b0;
    end else if (at_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      req.rdy <= 1'b1; // one cycle after done
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rd_req || req.wr_req) addr_r <= addr_t'(req.addr); // drop unused top bits
  end

  // -------------------------------------------------------------------------
  // access sequencer
  // -------------------------------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset || revive) begin
      // console woke up, a running access starts over from idle
      state <= snes_mem_pkg::ST_IDLE;
      delay <= '0;
    end else begin
      case (state)
        snes_mem_pkg::ST_IDLE: begin
          if (free_slot || dead) begin // bus is ours
            if (rd_pend) begin
              state <= snes_mem_pkg::ST_RD_ADDR;
              delay <= `SNES_DELAY_W'(cycle_len);
            end else if (wr_pend) begin
              state <= snes_mem_pkg::ST_WR_ADDR;
              delay <= `SNES_DELAY_W'(cycle_len);
            end
          end
        end
        snes_mem_pkg::ST_RD_ADDR, snes_mem_pkg::ST_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= (state == snes_mem_pkg::ST_RD_ADDR) ? snes_mem_pkg::ST_RD_END
                                                         : snes_mem_pkg::ST_WR_END;
          end
        end
        snes_mem_pkg::ST_RD_END, snes_mem_pkg::ST_WR_END: state <= snes_mem_pkg::ST_IDLE;
        default: state <= snes_mem_pkg::ST_IDLE;
      endcase
    end
  end

  // sample every address cycle, last one wins
  always_ff @(posedge CLK2) begin
    if (state == snes_mem_pkg::ST_RD_ADDR) rdata_r <= rd_byte;
  end

  assign req.done  = at_end;
  assign req.rdata = rdata_r;

  assign status.rd_hit = (state == snes_mem_pkg::ST_RD_ADDR) ||
                         (state == snes_mem_pkg::ST_RD_END);
  assign status.wr_hit = (state == snes_mem_pkg::ST_WR_ADDR) ||
                         (state == snes_mem_pkg::ST_WR_END);
  assign status.we_hit = (state == snes_mem_pkg::ST_WR_ADDR); // strobe off in end state

  assign hit_addr = addr_r;

endmodule

`default_nettype wire

// File: source/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one request path from the mcu router into a memory channel
interface mem_req_if;

  logic                    rd_req; // one-cycle pulse
  logic                    wr_req; // one-cycle pulse
  snes_mem_pkg::mcu_addr_t addr;   // valid with the pulse
  snes_mem_pkg::byte_t     rdata;  // valid from done onward
  logic                    rdy;    // level, low while busy
  logic                    done;   // one cycle in the end state

  modport router (
    output rd_req, wr_req, addr,
    input  rdata, rdy, done
  );

  modport channel (
    input  rd_req, wr_req, addr,
    output rdata, rdy, done
  );

endinterface

`default_nettype wire

// File: source/snes_bus_sync.sv
`timescale 1ns/1ps
`default_nettype none
`include "snes_mem_macros.svh"

module snes_bus_sync (
  input  logic CLK2,
  input  logic reset,
  input  logic cpu_clk,
  input  logic romsel,
  output logic cycle_end,
  output logic free_slot,
  output logic dead,
  output logic snes_reset
);

  localparam int DEPTH = `SNES_SYNC_DEPTH;

  logic [DEPTH-1:0]            cpu_clk_sr; // bit 0 newest
  logic [DEPTH-1:0]            romsel_sr;
  logic [`SNES_DEAD_CNT_W-1:0] dead_cnt;
  logic                        cycle_start;
  logic                        romsel_s;
  logic                        free_strobe;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      cpu_clk_sr <= '0;
      romsel_sr  <= '1; // rom select is active low
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[DEPTH-2:0], cpu_clk};
      romsel_sr  <= {romsel_sr[DEPTH-2:0], romsel};
    end
  end

  // six stable samples then a change, bit 0 not yet trusted
  assign cycle_start = (cpu_clk_sr[DEPTH-1:1] == {{(DEPTH-2){1'b0}}, 1'b1});
  assign cycle_end   = (cpu_clk_sr[DEPTH-1:1] == {{(DEPTH-2){1'b1}}, 1'b0});

  // later taps, select settles after the clock edge
  assign romsel_s = romsel_sr[DEPTH-3] & romsel_sr[DEPTH-4];

  // console cycle not touching rom gives a second slot
  always_ff @(posedge CLK2) begin
    if (reset) free_strobe <= 1'b0;
    else       free_strobe <= cycle_start & romsel_s;
  end

  assign free_slot = cycle_end | free_strobe;

  // -------------------------------------------------------------------------
  // dead console watchdog
  // -------------------------------------------------------------------------

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt <= '0;
    end else if (cpu_clk_sr[1]) begin
      dead_cnt <= '0;
    end else if (!dead) begin
      dead_cnt <= dead_cnt + 1'b1; // frozen once dead
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead       <= 1'b1; // no clock seen yet
      snes_reset <= 1'b0;
    end else begin
      snes_reset <= 1'b0;
      if (cpu_clk_sr[1]) begin
        dead       <= 1'b0;
        snes_reset <= dead; // only on the dead to alive change
      end else if (dead_cnt > `SNES_DEAD_CNT_W'(`SNES_DEAD_TIMEOUT)) begin
        dead <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/snes_mem_macros.svh
`ifndef SNES_MEM_MACROS_SVH
`define SNES_MEM_MACROS_SVH

// access lengths in CLK2 cycles, address phase lasts len+1
`define SNES_ROM_CYCLE_LEN 7
`define SNES_RAM_CYCLE_LEN 5
`define SNES_DELAY_W       4

// console watchdog, roughly 1 ms of missing cpu clock
`define SNES_DEAD_TIMEOUT  84000
`define SNES_DEAD_CNT_W    18

// strobe synchronizer length
`define SNES_SYNC_DEPTH    8

// mcu 880000-8fffff goes to sram
`define SNES_RAM_REGION    5'b10001

`endif

// File: source/snes_mem_pkg.sv
`default_nettype none

package snes_mem_pkg;

  // address and data
  typedef logic [23:0] mcu_addr_t;
  typedef logic [23:0] rom_addr_t; // psram byte address
  typedef logic [18:0] ram_addr_t; // sram byte address, 512 KB
  typedef logic [7:0]  byte_t;

  // -------------------------------------------------------------------------
  // access sequencer
  // -------------------------------------------------------------------------

  // one-hot, one bit per state
  typedef enum logic [4:0] {
    ST_IDLE    = 5'b00001,
    ST_RD_ADDR = 5'b00010,
    ST_RD_END  = 5'b00100,
    ST_WR_ADDR = 5'b01000,
    ST_WR_END  = 5'b10000
  } chan_state_e;

  // what the pin driver needs to know about a channel
  typedef struct packed {
    logic rd_hit; // read address or end phase
    logic wr_hit; // write address or end phase
    logic we_hit; // write strobe low
  } chan_status_t;

endpackage

`default_nettype wire

// File: source/snes_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "snes_mem_macros.svh"

module snes_mem_top (
  input  logic                    CLK2,
  input  logic                    reset,
  // mcu
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  snes_mem_pkg::mcu_addr_t mcu_addr,
  input  snes_mem_pkg::byte_t     mcu_wdata,
  output snes_mem_pkg::byte_t     mcu_rdata,
  output logic                    mcu_rdy,
  // console
  input  logic                    snes_cpu_clk,
  input  logic                    snes_romsel,
  input  snes_mem_pkg::mcu_addr_t snes_addr,
  output logic                    snes_reset,
  // psram
  output logic [22:0]             rom_addr,
  input  logic [15:0]             rom_rdata,
  output logic [15:0]             rom_wdata,
  output logic [1:0]              rom_wdata_en,
  output logic                    rom_we,
  output logic                    rom_bhe,
  output logic                    rom_ble,
  // sram
  output logic [18:0]             ram_addr,
  input  snes_mem_pkg::byte_t     ram_rdata,
  output snes_mem_pkg::byte_t     ram_wdata,
  output logic                    ram_wdata_en,
  output logic                    ram_we
);

  logic                       free_slot;
  logic                       dead;
  snes_mem_pkg::chan_status_t rom_status;
  snes_mem_pkg::chan_status_t ram_status;
  snes_mem_pkg::rom_addr_t    rom_hit_addr;
  snes_mem_pkg::ram_addr_t    ram_hit_addr;
  snes_mem_pkg::byte_t        rom_byte;

  mem_req_if rom_if ();
  mem_req_if ram_if ();

  snes_bus_sync u_bus_sync (
    .CLK2 (CLK2), .reset (reset), .cpu_clk (snes_cpu_clk), .romsel (snes_romsel),
    .cycle_end (), .free_slot (free_slot), .dead (dead), .snes_reset (snes_reset)
  );

  mcu_req_router u_router (
    .CLK2 (CLK2), .reset (reset), .mcu_rrq (mcu_rrq), .mcu_wrq (mcu_wrq),
    .mcu_addr (mcu_addr), .mcu_rdata (mcu_rdata), .mcu_rdy (mcu_rdy),
    .rom_req (rom_if.router), .ram_req (ram_if.router)
  );

  // revival strobe doubles as the sequencer restart
  mem_channel #(.addr_t (snes_mem_pkg::rom_addr_t), .cycle_len (`SNES_ROM_CYCLE_LEN)) u_rom_chan (
    .CLK2 (CLK2), .reset (reset), .free_slot (free_slot), .dead (dead), .revive (snes_reset),
    .req (rom_if.channel), .rd_byte (rom_byte), .status (rom_status), .hit_addr (rom_hit_addr)
  );

  mem_channel #(.addr_t (snes_mem_pkg::ram_addr_t), .cycle_len (`SNES_RAM_CYCLE_LEN)) u_ram_chan (
    .CLK2 (CLK2), .reset (reset), .free_slot (free_slot), .dead (dead), .revive (snes_reset),
    .req (ram_if.channel), .rd_byte (ram_rdata), .status (ram_status), .hit_addr (ram_hit_addr)
  );

  ext_mem_pins u_pins (
    .rom_status (rom_status), .ram_status (ram_status),
    .rom_hit_addr (rom_hit_addr), .ram_hit_addr (ram_hit_addr),
    .snes_addr (snes_addr), .mcu_wdata (mcu_wdata), .rom_rdata (rom_rdata),
    .rom_addr (rom_addr), .rom_wdata (rom_wdata), .rom_wdata_en (rom_wdata_en),
    .rom_we (rom_we), .rom_bhe (rom_bhe), .rom_ble (rom_ble),
    .ram_addr (ram_addr), .ram_wdata (ram_wdata), .ram_wdata_en (ram_wdata_en),
    .ram_we (ram_we), .rom_byte (rom_byte)
  );

endmodule

`default_nettype wire

// File: verification/snes_mem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module snes_mem_chk (
  input logic                      CLK2,
  input logic                      reset,
  input snes_mem_pkg::chan_state_e state,
  input logic                      rd_req,
  input logic                      wr_req,
  input logic                      rdy,
  input logic                      done
);

  // sequencer holds exactly one state bit
  a_onehot: assert property (@(posedge CLK2) disable iff (reset) $onehot(state))
    else $error("channel state %b is not one-hot", state);

  // busy from the cycle after the pulse
  a_busy: assert property (@(posedge CLK2) disable iff (reset)
    (rd_req || wr_req) |=> !rdy) else $error("rdy still high after a request");

  a_rdy_rise: assert property (@(posedge CLK2) disable iff (reset)
    $rose(rdy) |-> $past(done)) else $error("rdy rose without a done");

  a_done_len: assert property (@(posedge CLK2) disable iff (reset)
    done |=> !done) else $error("done longer than one cycle");

endmodule

bind mem_channel snes_mem_chk u_chk (
  .CLK2 (CLK2), .reset (reset), .state (state),
  .rd_req (req.rd_req), .wr_req (req.wr_req), .rdy (req.rdy), .done (at_end)
);

`default_nettype wire

// File: verification/snes_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "snes_mem_macros.svh"

module snes_mem_tb;

  localparam int TIMEOUT = 2000; // CLK2 cycles per wait
  localparam int N_ACC   = 24;

  logic                    CLK2;
  logic                    reset;
  logic                    mcu_rrq, mcu_wrq, mcu_rdy;
  snes_mem_pkg::mcu_addr_t mcu_addr, snes_addr;
  snes_mem_pkg::byte_t     mcu_wdata, mcu_rdata, ram_rdata, ram_wdata;
  logic                    snes_cpu_clk, snes_romsel, snes_reset;
  logic [22:0]             rom_addr;
  logic [15:0]             rom_rdata, rom_wdata;
  logic [1:0]              rom_wdata_en;
  logic                    rom_we, rom_bhe, rom_ble, ram_wdata_en, ram_we;
  logic [18:0]             ram_addr;

  // models and shadow keyed by byte address
  snes_mem_pkg::byte_t     rom_mem [snes_mem_pkg::rom_addr_t];
  snes_mem_pkg::byte_t     ram_mem [snes_mem_pkg::ram_addr_t];
  snes_mem_pkg::byte_t     rom_shadow [snes_mem_pkg::rom_addr_t];
  snes_mem_pkg::byte_t     ram_shadow [snes_mem_pkg::ram_addr_t];
  snes_mem_pkg::mcu_addr_t addr_q [$];

  int                      val_errs, other_errs, we_run, reset_pulses;
  int                      cpu_div, cpu_falls, fall_mark;
  logic                    cpu_run, cpu_clk_q, watch_we;
  snes_mem_pkg::mcu_addr_t cur_addr;
  snes_mem_pkg::byte_t     cur_data;

  snes_mem_top u_snes_mem_top (.*);

  always #4 CLK2 = ~CLK2;

  // console cpu clock with 12 CLK2 cycles per half period
  always @(posedge CLK2) begin
    if (cpu_run) begin
      cpu_div <= (cpu_div == 11) ? 0 : cpu_div + 1;
      if (cpu_div == 11) snes_cpu_clk <= ~snes_cpu_clk;
    end
  end

  // --------------------------------------------------------------------------
  // memory models
  // --------------------------------------------------------------------------

  function automatic snes_mem_pkg::byte_t fill_byte(snes_mem_pkg::mcu_addr_t a,
                                                    snes_mem_pkg::byte_t salt);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ salt;
  endfunction

  function automatic snes_mem_pkg::byte_t rom_peek(snes_mem_pkg::rom_addr_t a);
    return rom_mem.exists(a) ? rom_mem[a] : fill_byte(a, 8'h5a);
  endfunction

  function automatic snes_mem_pkg::byte_t ram_peek(snes_mem_pkg::ram_addr_t a);
    return ram_mem.exists(a) ? ram_mem[a] : fill_byte({5'b0, a}, 8'ha5);
  endfunction

  always @(posedge CLK2) begin
    if (!rom_we && !rom_ble) rom_mem[{rom_addr, 1'b1}] = rom_wdata[7:0]; // odd byte
    if (!rom_we && !rom_bhe) rom_mem[{rom_addr, 1'b0}] = rom_wdata[15:8];
    if (!ram_we) ram_mem[ram_addr] = ram_wdata;
    rom_rdata <= {rom_peek({rom_addr, 1'b0}), rom_peek({rom_addr, 1'b1})};
    ram_rdata <= ram_peek(ram_addr);
  end

  // expected read from the shadow where unwritten bytes keep the fill
  function automatic snes_mem_pkg::byte_t expect_byte(snes_mem_pkg::mcu_addr_t a);
    if (a[23:19] == `SNES_RAM_REGION) begin
      return ram_shadow.exists(a[18:0]) ? ram_shadow[a[18:0]] : fill_byte({5'b0, a[18:0]}, 8'ha5);
    end
    return rom_shadow.exists(a) ? rom_shadow[a] : fill_byte(a, 8'h5a);
  endfunction

  task automatic check_byte(snes_mem_pkg::byte_t got, snes_mem_pkg::byte_t exp, string what);
    if (got !== exp) begin
      val_errs++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(snes_mem_pkg::mcu_addr_t got, snes_mem_pkg::mcu_addr_t exp,
                            string what);
    if (got !== exp) begin
      val_errs++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // pin monitor sampled mid cycle
  always @(negedge CLK2) begin
    if (snes_reset) reset_pulses++;
    if (cpu_clk_q && !snes_cpu_clk) cpu_falls++;
    cpu_clk_q = snes_cpu_clk;
    if (watch_we && cpu_falls == fall_mark && !(rom_we && ram_we)) begin
      other_errs++;
      $display("Error at %0t ns: write strobe before the console clock fell", $time);
    end
    if (!rom_we) begin
      we_run++;
      check_addr({rom_addr, rom_bhe}, cur_addr, "psram word and bhe");
      check_byte({4'b0, rom_wdata_en, rom_ble, rom_bhe},
                 {4'b0, ~cur_addr[0], cur_addr[0], ~cur_addr[0], cur_addr[0]}, "psram lanes");
      check_byte(cur_addr[0] ? rom_wdata[7:0] : rom_wdata[15:8], cur_data, "psram wdata");
    end else if (we_run != 0) begin
      check_byte(8'(we_run), 8'(`SNES_ROM_CYCLE_LEN + 1), "rom_we low cycles");
      we_run = 0;
    end
    if (!ram_we) begin
      check_addr({5'b0, ram_addr}, {5'b0, cur_addr[18:0]}, "sram address");
      check_byte(ram_wdata, cur_data, "sram wdata");
      check_byte({7'b0, ram_wdata_en}, 8'h01, "sram wdata enable");
    end
  end

  // --------------------------------------------------------------------------
  // mcu side
  // --------------------------------------------------------------------------

  task automatic end_run();
    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic mcu_access(logic wr, snes_mem_pkg::mcu_addr_t a, snes_mem_pkg::byte_t d);
    int n;
    n = 0;
    @(posedge CLK2);
    cur_addr = a;
    cur_data = d;
    mcu_addr  <= a;
    mcu_wdata <= d;
    mcu_rrq   <= !wr;
    mcu_wrq   <= wr;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    while (!mcu_rdy && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    watch_we = 1'b0;
    if (!mcu_rdy) begin
      other_errs++;
      $display("Error at %0t ns: mcu_rdy stayed low after an access to %h", $time, a);
      end_run();
    end else if (!wr) begin
      check_byte(mcu_rdata, expect_byte(a), "mcu read data");
    end else if (a[23:19] == `SNES_RAM_REGION) begin
      ram_shadow[a[18:0]] = d;
    end else begin
      rom_shadow[a] = d;
    end
  endtask

  // issue during the high half of a console cycle
  task automatic wait_mid_cycle();
    int n;
    n = 0;
    @(negedge CLK2);
    while (!snes_cpu_clk && n < TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    if (!snes_cpu_clk) begin
      other_errs++;
      $display("Error at %0t ns: console clock never went high", $time);
      end_run();
    end else begin
      fall_mark = cpu_falls;
      watch_we  = 1'b1;
    end
  endtask

  function automatic snes_mem_pkg::mcu_addr_t rand_addr(logic to_ram);
    snes_mem_pkg::mcu_addr_t a;
    a = 24'($urandom);
    if (to_ram) a[23:19] = `SNES_RAM_REGION;
    else if (a[23:19] == `SNES_RAM_REGION) a[23] = 1'b0;
    return a;
  endfunction

  task automatic run_burst(logic to_ram, logic mid_cycle);
    snes_mem_pkg::mcu_addr_t a;
    addr_q.delete();
    repeat (N_ACC) begin
      a = rand_addr(to_ram);
      addr_q.push_back(a);
      if (mid_cycle) wait_mid_cycle();
      mcu_access(1'b1, a, 8'($urandom));
    end
    addr_q.push_back(rand_addr(to_ram)); // one address never written
    foreach (addr_q[i]) begin
      if (mid_cycle) wait_mid_cycle();
      mcu_access(1'b0, addr_q[i], 8'h00);
    end
  endtask

  // every model byte must come from a write the MCU made
  task automatic check_models();
    foreach (rom_mem[k]) begin
      if (!rom_shadow.exists(k)) begin
        other_errs++;
        $display("Error at %0t ns: psram changed at %h, never written there", $time, k);
      end else begin
        check_byte(rom_mem[k], rom_shadow[k], "psram model");
      end
    end
    foreach (ram_mem[k]) begin
      if (!ram_shadow.exists(k)) begin
        other_errs++;
        $display("Error at %0t ns: sram changed at %h, never written there", $time, k);
      end else begin
        check_byte(ram_mem[k], ram_shadow[k], "sram model");
      end
    end
  endtask

  initial begin
    CLK2         = 1'b0;
    reset        = 1'b1;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = '0;
    mcu_wdata    = '0;
    snes_cpu_clk = 1'b0;
    snes_romsel  = 1'b0; // rom select held low throughout
    snes_addr    = 24'h00_1234;
    rom_rdata    = '0;
    ram_rdata    = '0;
    val_errs     = 0;
    other_errs   = 0;
    we_run       = 0;
    reset_pulses = 0;
    cpu_div      = 0;
    cpu_falls    = 0;
    fall_mark    = 0;
    cpu_run      = 1'b0;
    cpu_clk_q    = 1'b0;
    watch_we     = 1'b0;
    void'($urandom(58));
    repeat (2) @(posedge CLK2);
    reset <= 1'b0;
    @(negedge CLK2);
    check_byte({1'b0, rom_we, ram_we, mcu_rdy, rom_wdata_en, ram_wdata_en, snes_reset},
               8'b0111_0000, "outputs after reset");
    run_burst(1'b0, 1'b0); // psram with the console dead
    run_burst(1'b1, 1'b0); // sram with the console dead
    @(posedge CLK2);
    cpu_run <= 1'b1;
    repeat (200) @(posedge CLK2);
    check_byte(8'(reset_pulses), 8'd1, "snes_reset high cycles");
    run_burst(1'b0, 1'b1);
    run_burst(1'b1, 1'b1);
    check_byte(8'(reset_pulses), 8'd1, "snes_reset high cycles at end");
    check_models();
    end_run();
  end

endmodule

`default_nettype wire
